/* rtl/soc_irq_defs.svh */
`ifndef SOC_IRQ_DEFS_SVH
`define SOC_IRQ_DEFS_SVH

// Widths
`define SOC_GPIO_WIDTH 8                // GPIO pins, also PLIC sources
`define SOC_PRIO_BITS 3
`define SOC_REG_AW 8                    // Byte address
`define SOC_DATA_W 32
`define SOC_SEL_W 2
`define SOC_MTIME_W 64
`define SOC_ID_W 4                      // Claim id 0..8

// Block select codes
`define SOC_SEL_GPIO 2'd0
`define SOC_SEL_CLINT 2'd1
`define SOC_SEL_PLIC 2'd2

// GPIO register offsets
`define SOC_GPIO_IN 8'h00               // Synced pin value
`define SOC_GPIO_IE 8'h04
`define SOC_GPIO_PEND 8'h08             // Write 1 to clear
`define SOC_GPIO_OUT 8'h0C
`define SOC_GPIO_DIR 8'h10

// CLINT register offsets
`define SOC_CLINT_MSIP 8'h00
`define SOC_CLINT_CMP_LO 8'h08
`define SOC_CLINT_CMP_HI 8'h0C
`define SOC_CLINT_TIME_LO 8'h10
`define SOC_CLINT_TIME_HI 8'h14

// PLIC register offsets
`define SOC_PLIC_PRIO 8'h00             // Source n at 4*(n-1)
`define SOC_PLIC_ENA0 8'h20
`define SOC_PLIC_ENA1 8'h24
`define SOC_PLIC_THR0 8'h28
`define SOC_PLIC_THR1 8'h2C
`define SOC_PLIC_CLAIM0 8'h30
`define SOC_PLIC_CLAIM1 8'h34

`endif

/* rtl/soc_irq_pkg.sv */
`include "soc_irq_defs.svh"

package soc_irq_pkg;

    // Plain vectors for widths with a meaning
    typedef logic [`SOC_REG_AW-1:0] reg_addr_t;
    typedef logic [`SOC_DATA_W-1:0] reg_data_t;
    typedef logic [`SOC_SEL_W-1:0] blk_sel_t;
    typedef logic [`SOC_GPIO_WIDTH-1:0] irq_vec_t;    // One bit per pin or source
    typedef logic [`SOC_PRIO_BITS-1:0] prio_t;        // Priority or threshold
    typedef logic [`SOC_MTIME_W-1:0] mtime_t;

    // Register bus request, one cycle strobe
    typedef struct packed
    {
        logic valid;
        logic write;
        blk_sel_t sel;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    // Response one cycle after the request
    // rdata stays zero when valid is low so responses can be ORed
    typedef struct packed
    {
        logic valid;
        reg_data_t rdata;
    } reg_rsp_t;

endpackage: soc_irq_pkg

/* rtl/irq_gpio.sv */
`timescale 1ns/10ps
`include "soc_irq_defs.svh"

module irq_gpio
(
    input logic i_clk,
    input logic i_arst_n,
    input soc_irq_pkg::reg_req_t i_req,
    output soc_irq_pkg::reg_rsp_t o_rsp,
    input soc_irq_pkg::irq_vec_t i_gpio,                 // Asynchronous pins
    output soc_irq_pkg::irq_vec_t o_gpio,
    output soc_irq_pkg::irq_vec_t o_gpio_dir,
    output soc_irq_pkg::irq_vec_t o_irq
);

soc_irq_pkg::irq_vec_t gpio_meta;
soc_irq_pkg::irq_vec_t gpio_sync;
soc_irq_pkg::irq_vec_t gpio_prev;                       // For edge detect
soc_irq_pkg::irq_vec_t irq_ena;
soc_irq_pkg::irq_vec_t pending;
soc_irq_pkg::irq_vec_t rise;
soc_irq_pkg::irq_vec_t pend_clr;
soc_irq_pkg::reg_data_t rdata;
logic req_hit;
logic wr_hit;
logic pend_wr;

assign req_hit = i_req.valid && (i_req.sel == `SOC_SEL_GPIO);
assign wr_hit = req_hit && i_req.write;
assign pend_wr = wr_hit && (i_req.addr == `SOC_GPIO_PEND);

assign rise = gpio_sync & ~gpio_prev;
assign pend_clr = pend_wr ? soc_irq_pkg::irq_vec_t'(i_req.wdata) : '0;

// Read mux on current register values
always_comb
begin
    case (i_req.addr)
        `SOC_GPIO_IN:   rdata = soc_irq_pkg::reg_data_t'(gpio_sync);
        `SOC_GPIO_IE:   rdata = soc_irq_pkg::reg_data_t'(irq_ena);
        `SOC_GPIO_PEND: rdata = soc_irq_pkg::reg_data_t'(pending);
        `SOC_GPIO_OUT:  rdata = soc_irq_pkg::reg_data_t'(o_gpio);
        `SOC_GPIO_DIR:  rdata = soc_irq_pkg::reg_data_t'(o_gpio_dir);
        default:        rdata = '0;
    endcase
end

always_ff @(posedge i_clk or negedge i_arst_n)
begin
    if (!i_arst_n)
    begin
        gpio_meta <= '0;
        gpio_sync <= '0;
        gpio_prev <= '0;
        irq_ena <= '0;
        pending <= '0;
        o_gpio <= '0;
        o_gpio_dir <= '0;
        o_irq <= '0;
        o_rsp <= '0;
    end
    else
    begin
        gpio_meta <= i_gpio;
        gpio_sync <= gpio_meta;
        gpio_prev <= gpio_sync;
        pending <= (pending & ~pend_clr) | rise;        // Edge wins over clear
        o_irq <= pending & irq_ena;
        if (wr_hit)
        begin
            case (i_req.addr)
                `SOC_GPIO_IE:  irq_ena <= soc_irq_pkg::irq_vec_t'(i_req.wdata);
                `SOC_GPIO_OUT: o_gpio <= soc_irq_pkg::irq_vec_t'(i_req.wdata);
                `SOC_GPIO_DIR: o_gpio_dir <= soc_irq_pkg::irq_vec_t'(i_req.wdata);
                default: ;
            endcase
        end
        o_rsp.valid <= req_hit;
        o_rsp.rdata <= (req_hit && !i_req.write) ? rdata : '0;
    end
end

// Each response needs its own selected request
a_rsp_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_rsp.valid && !req_hit |=> !o_rsp.valid);

// Pending only falls through a write to the pending register
a_pend_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !pend_wr |=> ((pending & $past(pending)) == $past(pending)));

endmodule: irq_gpio

/* rtl/irq_clint.sv */
`timescale 1ns/10ps
`include "soc_irq_defs.svh"

module irq_clint
(
    input logic i_clk,
    input logic i_arst_n,
    input soc_irq_pkg::reg_req_t i_req,
    output soc_irq_pkg::reg_rsp_t o_rsp,
    output logic o_mtip,                                // Timer interrupt
    output logic o_msip                                 // Software interrupt
);

soc_irq_pkg::mtime_t mtime;
soc_irq_pkg::mtime_t mtimecmp;
soc_irq_pkg::reg_data_t rdata;
logic req_hit;
logic wr_hit;

assign req_hit = i_req.valid && (i_req.sel == `SOC_SEL_CLINT);
assign wr_hit = req_hit && i_req.write;

always_comb
begin
    case (i_req.addr)
        `SOC_CLINT_MSIP:    rdata = soc_irq_pkg::reg_data_t'(o_msip);
        `SOC_CLINT_CMP_LO:  rdata = mtimecmp[`SOC_DATA_W-1:0];
        `SOC_CLINT_CMP_HI:  rdata = mtimecmp[`SOC_MTIME_W-1:`SOC_DATA_W];
        `SOC_CLINT_TIME_LO: rdata = mtime[`SOC_DATA_W-1:0];
        `SOC_CLINT_TIME_HI: rdata = mtime[`SOC_MTIME_W-1:`SOC_DATA_W];
        default:            rdata = '0;
    endcase
end

// Free running timer
// A write to one half replaces this cycle's increment
always_ff @(posedge i_clk or negedge i_arst_n)
begin
    if (!i_arst_n)
    begin
        mtime <= '0;
    end
    else if (wr_hit && (i_req.addr == `SOC_CLINT_TIME_LO))
    begin
        mtime <= {mtime[`SOC_MTIME_W-1:`SOC_DATA_W], i_req.wdata};
    end
    else if (wr_hit && (i_req.addr == `SOC_CLINT_TIME_HI))
    begin
        mtime <= {i_req.wdata, mtime[`SOC_DATA_W-1:0]};
    end
    else
    begin
        mtime <= mtime + 1'b1;
    end
end

always_ff @(posedge i_clk or negedge i_arst_n)
begin
    if (!i_arst_n)
    begin
        mtimecmp <= '1;                                 // Compare never hits
        o_msip <= 1'b0;
        o_mtip <= 1'b0;
        o_rsp <= '0;
    end
    else
    begin
        o_mtip <= (mtime >= mtimecmp);
        if (wr_hit)
        begin
            case (i_req.addr)
                `SOC_CLINT_MSIP:   o_msip <= i_req.wdata[0];
                `SOC_CLINT_CMP_LO: mtimecmp[`SOC_DATA_W-1:0] <= i_req.wdata;
                `SOC_CLINT_CMP_HI: mtimecmp[`SOC_MTIME_W-1:`SOC_DATA_W] <= i_req.wdata;
                default: ;
            endcase
        end
        o_rsp.valid <= req_hit;
        o_rsp.rdata <= (req_hit && !i_req.write) ? rdata : '0;
    end
end

// No timer interrupt while compare is parked at all ones
a_mtip_parked: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (&mtimecmp) && !(&mtime) |=> !o_mtip);

endmodule: irq_clint

/* rtl/irq_plic.sv */
`timescale 1ns/10ps
`include "soc_irq_defs.svh"

module irq_plic
(
    input logic i_clk,
    input logic i_arst_n,
    input soc_irq_pkg::reg_req_t i_req,
    input soc_irq_pkg::reg_rsp_t i_gpio_rsp,
    input soc_irq_pkg::reg_rsp_t i_clint_rsp,
    output soc_irq_pkg::reg_rsp_t o_rsp,                // Merged bus response
    input soc_irq_pkg::irq_vec_t i_irq,
    output logic o_meip,                                // Context 0
    output logic o_seip                                 // Context 1
);

soc_irq_pkg::prio_t [`SOC_GPIO_WIDTH-1:0] prio;         // Index 0 is source id 1
soc_irq_pkg::irq_vec_t ena0;
soc_irq_pkg::irq_vec_t ena1;
soc_irq_pkg::prio_t thr0;
soc_irq_pkg::prio_t thr1;
logic [`SOC_ID_W-1:0] claim0;
logic [`SOC_ID_W-1:0] claim1;
soc_irq_pkg::reg_addr_t prio_off;
logic [$clog2(`SOC_GPIO_WIDTH)-1:0] prio_idx;
logic prio_hit;
soc_irq_pkg::reg_data_t rdata;
soc_irq_pkg::reg_rsp_t own_rsp;
logic req_hit;
logic wr_hit;

// Highest priority above threshold, ties to the lowest id, 0 when none
function automatic logic [`SOC_ID_W-1:0] pick_id(
    input soc_irq_pkg::irq_vec_t lines,
    input soc_irq_pkg::prio_t [`SOC_GPIO_WIDTH-1:0] pr,
    input soc_irq_pkg::prio_t thr
);
    logic [`SOC_ID_W-1:0] best_id;
    soc_irq_pkg::prio_t best_pr;

    best_id = '0;
    best_pr = thr;                                      // Must beat the threshold
    for (int i = 0; i < `SOC_GPIO_WIDTH; i++)
    begin
        if (lines[i] && (pr[i] > best_pr))              // Strict so ties keep lower id
        begin
            best_pr = pr[i];
            best_id = `SOC_ID_W'(i + 1);
        end
    end
    return best_id;
endfunction

assign claim0 = pick_id(i_irq & ena0, prio, thr0);
assign claim1 = pick_id(i_irq & ena1, prio, thr1);
assign o_meip = (claim0 != '0);
assign o_seip = (claim1 != '0);

assign req_hit = i_req.valid && (i_req.sel == `SOC_SEL_PLIC);
assign wr_hit = req_hit && i_req.write;

// Priority array decode
assign prio_off = i_req.addr - `SOC_PLIC_PRIO;
assign prio_hit = (prio_off < soc_irq_pkg::reg_addr_t'(4 * `SOC_GPIO_WIDTH))
                  && (prio_off[1:0] == 2'b00);
assign prio_idx = prio_off[2 +: $clog2(`SOC_GPIO_WIDTH)];

always_comb
begin
    if (prio_hit)
    begin
        rdata = soc_irq_pkg::reg_data_t'(prio[prio_idx]);
    end
    else
    begin
        case (i_req.addr)
            `SOC_PLIC_ENA0:   rdata = soc_irq_pkg::reg_data_t'(ena0);
            `SOC_PLIC_ENA1:   rdata = soc_irq_pkg::reg_data_t'(ena1);
            `SOC_PLIC_THR0:   rdata = soc_irq_pkg::reg_data_t'(thr0);
            `SOC_PLIC_THR1:   rdata = soc_irq_pkg::reg_data_t'(thr1);
            `SOC_PLIC_CLAIM0: rdata = soc_irq_pkg::reg_data_t'(claim0);  // No side effect
            `SOC_PLIC_CLAIM1: rdata = soc_irq_pkg::reg_data_t'(claim1);
            default:          rdata = '0;
        endcase
    end
end

always_ff @(posedge i_clk or negedge i_arst_n)
begin
    if (!i_arst_n)
    begin
        prio <= '0;
        ena0 <= '0;
        ena1 <= '0;
        thr0 <= '0;
        thr1 <= '0;
        own_rsp <= '0;
    end
    else
    begin
        if (wr_hit && prio_hit)
        begin
            prio[prio_idx] <= i_req.wdata[`SOC_PRIO_BITS-1:0];
        end
        else if (wr_hit)
        begin
            case (i_req.addr)
                `SOC_PLIC_ENA0: ena0 <= i_req.wdata[`SOC_GPIO_WIDTH-1:0];
                `SOC_PLIC_ENA1: ena1 <= i_req.wdata[`SOC_GPIO_WIDTH-1:0];
                `SOC_PLIC_THR0: thr0 <= i_req.wdata[`SOC_PRIO_BITS-1:0];
                `SOC_PLIC_THR1: thr1 <= i_req.wdata[`SOC_PRIO_BITS-1:0];
                default: ;
            endcase
        end
        own_rsp.valid <= req_hit;
        own_rsp.rdata <= (req_hit && !i_req.write) ? rdata : '0;
    end
end

// Idle responses are all zero so a plain OR merges them
assign o_rsp = soc_irq_pkg::reg_rsp_t'(own_rsp | i_gpio_rsp | i_clint_rsp);

// Only one block answers in a cycle
a_rsp_onehot: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    $onehot0({own_rsp.valid, i_gpio_rsp.valid, i_clint_rsp.valid}));

endmodule: irq_plic

/* rtl/irq_soc_top.sv */
`timescale 1ns/10ps

module irq_soc_top
(
    input logic i_sys_clk,                              // System and bus clock
    input logic i_arst_n,
    input soc_irq_pkg::reg_req_t i_req,
    output soc_irq_pkg::reg_rsp_t o_rsp,
    input soc_irq_pkg::irq_vec_t i_gpio,
    output soc_irq_pkg::irq_vec_t o_gpio,
    output soc_irq_pkg::irq_vec_t o_gpio_dir,
    output logic o_mtip,
    output logic o_msip,
    output logic o_meip,
    output logic o_seip
);

soc_irq_pkg::reg_rsp_t gpio_rsp;
soc_irq_pkg::reg_rsp_t clint_rsp;
soc_irq_pkg::irq_vec_t gpio_irq;                        // GPIO lines into PLIC sources

irq_gpio gpio0
(
    .i_clk(i_sys_clk),
    .i_arst_n(i_arst_n),
    .i_req(i_req),
    .o_rsp(gpio_rsp),
    .i_gpio(i_gpio),
    .o_gpio(o_gpio),
    .o_gpio_dir(o_gpio_dir),
    .o_irq(gpio_irq)
);

irq_clint clint0
(
    .i_clk(i_sys_clk),
    .i_arst_n(i_arst_n),
    .i_req(i_req),
    .o_rsp(clint_rsp),
    .o_mtip(o_mtip),
    .o_msip(o_msip)
);

// PLIC also merges the other two responses
irq_plic plic0
(
    .i_clk(i_sys_clk),
    .i_arst_n(i_arst_n),
    .i_req(i_req),
    .i_gpio_rsp(gpio_rsp),
    .i_clint_rsp(clint_rsp),
    .o_rsp(o_rsp),
    .i_irq(gpio_irq),
    .o_meip(o_meip),
    .o_seip(o_seip)
);

endmodule: irq_soc_top

/* test/tb_irq_soc.sv */
`timescale 1ns/10ps
`include "soc_irq_defs.svh"

module tb_irq_soc;

localparam int MAX_CYCLES = 3000;                       // Well above the full test run

logic clk;
logic arst_n;
soc_irq_pkg::reg_req_t req;
soc_irq_pkg::reg_rsp_t rsp;
soc_irq_pkg::irq_vec_t gpio_in;
soc_irq_pkg::irq_vec_t gpio_out;
soc_irq_pkg::irq_vec_t gpio_dir;
logic mtip;
logic msip;
logic meip;
logic seip;
int errors;
int cycles;
int seed_ret;

irq_soc_top uut
(
    .i_sys_clk(clk),
    .i_arst_n(arst_n),
    .i_req(req),
    .o_rsp(rsp),
    .i_gpio(gpio_in),
    .o_gpio(gpio_out),
    .o_gpio_dir(gpio_dir),
    .o_mtip(mtip),
    .o_msip(msip),
    .o_meip(meip),
    .o_seip(seip)
);

always #20 clk = ~clk;

always @(posedge clk)
begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
        $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Errors found");
        $finish;
    end
end

task automatic check(input string name, input soc_irq_pkg::reg_data_t expected,
                     input soc_irq_pkg::reg_data_t actual);
    if (actual !== expected)
    begin
        $display("Fail %s expected 0x%08h actual 0x%08h", name, expected, actual);
        errors++;
    end
endtask

task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
endtask

// One request strobe, response taken on the next falling edge
task automatic bus_access(input logic write, input soc_irq_pkg::blk_sel_t sel,
                          input soc_irq_pkg::reg_addr_t addr,
                          input soc_irq_pkg::reg_data_t wdata,
                          output soc_irq_pkg::reg_data_t rdata);
    @(negedge clk);
    req.valid = 1'b1;
    req.write = write;
    req.sel = sel;
    req.addr = addr;
    req.wdata = wdata;
    @(negedge clk);
    req = '0;
    rdata = rsp.rdata;
    if (rsp.valid !== 1'b1)
    begin
        $display("No response came for the access to block %0d offset 0x%02h", sel, addr);
        errors++;
    end
endtask

task automatic bus_write(input soc_irq_pkg::blk_sel_t sel, input soc_irq_pkg::reg_addr_t addr,
                         input soc_irq_pkg::reg_data_t data);
    soc_irq_pkg::reg_data_t rdata;
    bus_access(1'b1, sel, addr, data, rdata);
    check("write response data", '0, rdata);            // Writes answer with zero
endtask

task automatic bus_read(input string name, input soc_irq_pkg::blk_sel_t sel,
                        input soc_irq_pkg::reg_addr_t addr,
                        input soc_irq_pkg::reg_data_t expected);
    soc_irq_pkg::reg_data_t rdata;
    bus_access(1'b0, sel, addr, '0, rdata);
    check(name, expected, rdata);
endtask

// Highest eligible priority first, then the lowest id holding it
function automatic int expected_claim(input soc_irq_pkg::irq_vec_t lines,
                                      input soc_irq_pkg::irq_vec_t ena,
                                      input soc_irq_pkg::prio_t [`SOC_GPIO_WIDTH-1:0] pr,
                                      input soc_irq_pkg::prio_t thr);
    int top;
    int id;
    top = 0;
    id = 0;
    for (int i = 0; i < `SOC_GPIO_WIDTH; i++)
    begin
        if (lines[i] && ena[i] && (pr[i] > thr) && (pr[i] > top))
        begin
            top = pr[i];
        end
    end
    for (int i = `SOC_GPIO_WIDTH - 1; i >= 0; i--)
    begin
        if (lines[i] && ena[i] && (top > 0) && (pr[i] == top))
        begin
            id = i + 1;
        end
    end
    return id;
endfunction

task automatic reset_state();
    check("reset rsp valid", 0, rsp.valid);
    check("reset mtip", 0, mtip);
    check("reset msip", 0, msip);
    check("reset meip", 0, meip);
    check("reset seip", 0, seip);
    check("reset gpio dir", 0, gpio_dir);
    bus_read("reset claim0", `SOC_SEL_PLIC, `SOC_PLIC_CLAIM0, 0);
    bus_read("reset claim1", `SOC_SEL_PLIC, `SOC_PLIC_CLAIM1, 0);
    bus_read("reset mtimecmp lo", `SOC_SEL_CLINT, `SOC_CLINT_CMP_LO, 32'hffff_ffff);
    bus_read("reset mtimecmp hi", `SOC_SEL_CLINT, `SOC_CLINT_CMP_HI, 32'hffff_ffff);
endtask

task automatic gpio_registers();
    soc_irq_pkg::irq_vec_t out_val;
    soc_irq_pkg::irq_vec_t dir_val;
    soc_irq_pkg::irq_vec_t pin_val;
    out_val = soc_irq_pkg::irq_vec_t'($urandom);
    dir_val = soc_irq_pkg::irq_vec_t'($urandom);
    pin_val = soc_irq_pkg::irq_vec_t'($urandom);
    bus_write(`SOC_SEL_GPIO, `SOC_GPIO_OUT, out_val);
    bus_write(`SOC_SEL_GPIO, `SOC_GPIO_DIR, dir_val);
    bus_read("gpio out readback", `SOC_SEL_GPIO, `SOC_GPIO_OUT, out_val);
    bus_read("gpio dir readback", `SOC_SEL_GPIO, `SOC_GPIO_DIR, dir_val);
    check("gpio out pins", out_val, gpio_out);
    check("gpio dir pins", dir_val, gpio_dir);
    gpio_in = pin_val;
    wait_cycles(8);
    bus_read("gpio input sync", `SOC_SEL_GPIO, `SOC_GPIO_IN, pin_val);
endtask

task automatic gpio_interrupt();
    gpio_in = '0;
    wait_cycles(8);
    bus_write(`SOC_SEL_GPIO, `SOC_GPIO_PEND, 32'hff);     // Drop edges left by earlier pins
    bus_read("pending cleared", `SOC_SEL_GPIO, `SOC_GPIO_PEND, 0);
    gpio_in = 8'h08;                                      // Pin 3 is source id 4
    wait_cycles(8);
    bus_read("pending after edge", `SOC_SEL_GPIO, `SOC_GPIO_PEND, 32'h08);
    check("meip with no enable", 0, meip);
    bus_write(`SOC_SEL_GPIO, `SOC_GPIO_IE, 32'h08);
    wait_cycles(8);
    check("meip with gpio enable only", 0, meip);
    bus_write(`SOC_SEL_PLIC, `SOC_PLIC_ENA0, 32'h08);
    wait_cycles(8);
    check("meip with priority 0", 0, meip);
    bus_write(`SOC_SEL_PLIC, `SOC_PLIC_PRIO + 8'h0C, 32'd5);
    wait_cycles(8);
    check("meip enabled", 1, meip);
    bus_read("claim0 single source", `SOC_SEL_PLIC, `SOC_PLIC_CLAIM0, 4);
    bus_write(`SOC_SEL_GPIO, `SOC_GPIO_PEND, 32'h08);
    wait_cycles(8);
    bus_read("pending after clear", `SOC_SEL_GPIO, `SOC_GPIO_PEND, 0);
    check("meip after clear", 0, meip);
    gpio_in = '0;
endtask

task automatic arb_round(input string name, input soc_irq_pkg::prio_t [`SOC_GPIO_WIDTH-1:0] pr,
                         input soc_irq_pkg::irq_vec_t ena0, input soc_irq_pkg::irq_vec_t ena1,
                         input soc_irq_pkg::prio_t thr0, input soc_irq_pkg::prio_t thr1);
    int id0;
    int id1;
    id0 = expected_claim('1, ena0, pr, thr0);             // All lines are held high
    id1 = expected_claim('1, ena1, pr, thr1);
    for (int i = 0; i < `SOC_GPIO_WIDTH; i++)
    begin
        bus_write(`SOC_SEL_PLIC, soc_irq_pkg::reg_addr_t'(4 * i), pr[i]);
    end
    bus_write(`SOC_SEL_PLIC, `SOC_PLIC_ENA0, ena0);
    bus_write(`SOC_SEL_PLIC, `SOC_PLIC_ENA1, ena1);
    bus_write(`SOC_SEL_PLIC, `SOC_PLIC_THR0, thr0);
    bus_write(`SOC_SEL_PLIC, `SOC_PLIC_THR1, thr1);
    bus_read({name, " claim0"}, `SOC_SEL_PLIC, `SOC_PLIC_CLAIM0, id0);
    bus_read({name, " claim1"}, `SOC_SEL_PLIC, `SOC_PLIC_CLAIM1, id1);
    check({name, " meip"}, id0 != 0, meip);
    check({name, " seip"}, id1 != 0, seip);
endtask

task automatic plic_arbitration();
    soc_irq_pkg::prio_t [`SOC_GPIO_WIDTH-1:0] pr;
    gpio_in = '0;                                         // Pins low first so every pin rises
    wait_cycles(8);
    gpio_in = '1;                                         // Edges on every pin set all pending
    bus_write(`SOC_SEL_GPIO, `SOC_GPIO_IE, 32'hff);
    wait_cycles(8);
    for (int r = 0; r < 4; r++)
    begin
        for (int i = 0; i < `SOC_GPIO_WIDTH; i++)
        begin
            pr[i] = soc_irq_pkg::prio_t'($urandom_range(0, 7));
        end
        arb_round("arb random", pr, soc_irq_pkg::irq_vec_t'($urandom),
                  soc_irq_pkg::irq_vec_t'($urandom), soc_irq_pkg::prio_t'($urandom_range(0, 3)),
                  soc_irq_pkg::prio_t'($urandom_range(0, 3)));
    end
    pr = {`SOC_GPIO_WIDTH{3'd4}};
    arb_round("arb tie", pr, 8'b1010_0100, 8'hff, 3'd3, 3'd4);   // Ctx 1 sits at threshold
    gpio_in = '0;
    bus_write(`SOC_SEL_GPIO, `SOC_GPIO_IE, 0);
    bus_write(`SOC_SEL_GPIO, `SOC_GPIO_PEND, 32'hff);
endtask

task automatic clint_timer();
    soc_irq_pkg::reg_data_t t0;
    soc_irq_pkg::reg_data_t t1;
    bus_write(`SOC_SEL_CLINT, `SOC_CLINT_MSIP, 1);
    check("msip set", 1, msip);
    bus_access(1'b0, `SOC_SEL_CLINT, `SOC_CLINT_TIME_LO, '0, t0);
    bus_access(1'b0, `SOC_SEL_CLINT, `SOC_CLINT_TIME_LO, '0, t1);
    check("mtime increases", 1, t1 > t0);
    bus_write(`SOC_SEL_CLINT, `SOC_CLINT_CMP_HI, 0);
    bus_write(`SOC_SEL_CLINT, `SOC_CLINT_CMP_LO, t1 + 20);
    check("mtip before compare", 0, mtip);
    wait_cycles(30);
    check("mtip after compare", 1, mtip);
    bus_write(`SOC_SEL_CLINT, `SOC_CLINT_CMP_LO, 32'hffff_ffff);
    bus_write(`SOC_SEL_CLINT, `SOC_CLINT_CMP_HI, 32'hffff_ffff);
    check("mtip parked", 0, mtip);
endtask

task automatic back_to_back();
    soc_irq_pkg::blk_sel_t sel_q[6];
    soc_irq_pkg::reg_addr_t addr_q[6];
    soc_irq_pkg::reg_data_t exp_q[6];
    soc_irq_pkg::irq_vec_t out_val;
    out_val = soc_irq_pkg::irq_vec_t'($urandom);
    bus_write(`SOC_SEL_GPIO, `SOC_GPIO_OUT, out_val);
    bus_write(`SOC_SEL_GPIO, `SOC_GPIO_DIR, 32'hc3);
    bus_write(`SOC_SEL_PLIC, `SOC_PLIC_THR0, 5);
    bus_write(`SOC_SEL_PLIC, `SOC_PLIC_THR1, 2);
    sel_q = '{`SOC_SEL_GPIO, `SOC_SEL_PLIC, `SOC_SEL_CLINT,
              `SOC_SEL_GPIO, `SOC_SEL_PLIC, `SOC_SEL_CLINT};
    addr_q = '{`SOC_GPIO_OUT, `SOC_PLIC_THR0, `SOC_CLINT_CMP_HI,
               `SOC_GPIO_DIR, `SOC_PLIC_THR1, `SOC_CLINT_MSIP};
    exp_q = '{out_val, 5, 32'hffff_ffff, 32'hc3, 2, 1};
    for (int i = 0; i <= 6; i++)
    begin
        @(negedge clk);
        if (i > 0)
        begin
            if (rsp.valid !== 1'b1)
            begin
                $display("No response came for back to back read %0d", i - 1);
                errors++;
            end
            check($sformatf("back to back read %0d", i - 1), exp_q[i - 1], rsp.rdata);
        end
        req = '0;
        if (i < 6)
        begin
            req.valid = 1'b1;
            req.sel = sel_q[i];
            req.addr = addr_q[i];
        end
    end
endtask

initial
begin
    clk = 1'b0;
    arst_n = 1'b0;
    req = '0;
    gpio_in = '0;
    errors = 0;
    seed_ret = $urandom(32'hfa6d_749a);
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    reset_state();
    gpio_registers();
    gpio_interrupt();
    plic_arbitration();
    clint_timer();
    back_to_back();
    wait_cycles(2);
    $display("Run complete with %0d errors", errors);
    if (errors == 0)
    begin
        $display("No errors");
    end
    else
    begin
        $display("Errors found");
    end
    $finish;
end

endmodule: tb_irq_soc

/* src.f */
+incdir+rtl
rtl/soc_irq_pkg.sv
rtl/irq_gpio.sv
rtl/irq_clint.sv
rtl/irq_plic.sv
rtl/irq_soc_top.sv
test/tb_irq_soc.sv

/* Bender.yml */
package:
  name: irq_soc

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/soc_irq_pkg.sv
      - rtl/irq_gpio.sv
      - rtl/irq_clint.sv
      - rtl/irq_plic.sv
      - rtl/irq_soc_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_irq_soc.sv
